// ==== hw/msrh_l2_pkg.sv ====
package msrh_l2_pkg;

   // widths that appear on the L2 request path
   localparam int PADDR_W      = 32;
   localparam int DATA_W       = 64;
   localparam int L2_CMD_TAG_W = 4;
   localparam int SRC_W        = 2;

   typedef logic [PADDR_W-1:0]      paddr_t;
   typedef logic [DATA_W-1:0]       l2_data_t;
   typedef logic [DATA_W/8-1:0]     l2_byte_en_t;
   typedef logic [L2_CMD_TAG_W-1:0] l2_tag_t;
   typedef logic [SRC_W-1:0]        src_id_t;

   // requester ids, also used as the index of each port
   localparam src_id_t SRC_ELF = 2'd0;
   localparam src_id_t SRC_IC  = 2'd1;
   localparam src_id_t SRC_L1D = 2'd2;
   localparam src_id_t SRC_PTW = 2'd3;

   typedef enum logic {
      M_RD = 1'b0,
      M_WR = 1'b1
   } mem_cmd_t;

   // request as a requester drives it
   typedef struct packed {
      mem_cmd_t    cmd;
      paddr_t      addr;
      l2_tag_t     tag;
      l2_data_t    data;
      l2_byte_en_t byte_en;
   } l2_req_t;

   // request after arbitration, tagged with its source
   typedef struct packed {
      src_id_t src;
      l2_req_t req;
   } l2_mem_req_t;

   typedef struct packed {
      src_id_t  src;
      l2_tag_t  tag;
      l2_data_t data;
   } l2_mem_resp_t;

   // response as a requester sees it
   typedef struct packed {
      l2_tag_t  tag;
      l2_data_t data;
   } l2_resp_t;

endpackage

// ==== hw/msrh_l2_req_arbiter.sv ====
module msrh_l2_req_arbiter (
   input  logic                      i_clk,

   // ELF loader
   input  logic                      i_elf_req_valid,
   input  msrh_l2_pkg::l2_req_t      i_elf_req,
   output logic                      o_elf_req_ready,

   // instruction cache
   input  logic                      i_ic_req_valid,
   input  msrh_l2_pkg::l2_req_t      i_ic_req,
   output logic                      o_ic_req_ready,

   // L1 data cache
   input  logic                      i_l1d_req_valid,
   input  msrh_l2_pkg::l2_req_t      i_l1d_req,
   output logic                      o_l1d_req_ready,

   // page table walker
   input  logic                      i_ptw_req_valid,
   input  msrh_l2_pkg::l2_req_t      i_ptw_req,
   output logic                      o_ptw_req_ready,

   // towards the L2 RAM
   output logic                      o_mem_req_valid,
   output msrh_l2_pkg::l2_mem_req_t  o_mem_req,
   input  logic                      i_mem_req_ready
);

   localparam int N_SRC = 1 << msrh_l2_pkg::SRC_W;

   // requests gathered by source id
   logic [N_SRC-1:0]      w_req_valid;
   msrh_l2_pkg::l2_req_t  w_req [N_SRC];

   logic                  w_any_valid;
   msrh_l2_pkg::src_id_t  w_win_src;
   logic [N_SRC-1:0]      w_grant;
   logic [N_SRC-1:0]      w_ready;

   assign w_req_valid[msrh_l2_pkg::SRC_ELF] = i_elf_req_valid;
   assign w_req_valid[msrh_l2_pkg::SRC_IC]  = i_ic_req_valid;
   assign w_req_valid[msrh_l2_pkg::SRC_L1D] = i_l1d_req_valid;
   assign w_req_valid[msrh_l2_pkg::SRC_PTW] = i_ptw_req_valid;

   assign w_req[msrh_l2_pkg::SRC_ELF] = i_elf_req;
   assign w_req[msrh_l2_pkg::SRC_IC]  = i_ic_req;
   assign w_req[msrh_l2_pkg::SRC_L1D] = i_l1d_req;
   assign w_req[msrh_l2_pkg::SRC_PTW] = i_ptw_req;

   // fixed priority, l1d first and the ELF loader last
   always_comb begin
      if (w_req_valid[msrh_l2_pkg::SRC_L1D]) begin
         w_win_src = msrh_l2_pkg::SRC_L1D;
      end else if (w_req_valid[msrh_l2_pkg::SRC_PTW]) begin
         w_win_src = msrh_l2_pkg::SRC_PTW;
      end else if (w_req_valid[msrh_l2_pkg::SRC_IC]) begin
         w_win_src = msrh_l2_pkg::SRC_IC;
      end else begin
         w_win_src = msrh_l2_pkg::SRC_ELF;
      end
   end

   assign w_any_valid = |w_req_valid;

   // one-hot grant, empty when nobody asks
   assign w_grant = w_any_valid ? (N_SRC'(1) << w_win_src) : '0;

   assign o_mem_req_valid = w_any_valid;
   assign o_mem_req       = '{src: w_win_src, req: w_req[w_win_src]};

   // RAM ready only reaches the winner
   assign w_ready = w_grant & {N_SRC{i_mem_req_ready}};

   assign o_elf_req_ready = w_ready[msrh_l2_pkg::SRC_ELF];
   assign o_ic_req_ready  = w_ready[msrh_l2_pkg::SRC_IC];
   assign o_l1d_req_ready = w_ready[msrh_l2_pkg::SRC_L1D];
   assign o_ptw_req_ready = w_ready[msrh_l2_pkg::SRC_PTW];

   // never two requesters handshaking on the same edge
   a_one_ready : assert property (
      @(posedge i_clk)
      $onehot0({o_elf_req_ready, o_ic_req_ready, o_l1d_req_ready, o_ptw_req_ready})
   );

endmodule

// ==== hw/msrh_l2_ram.sv ====
module msrh_l2_ram #(
   parameter msrh_l2_pkg::paddr_t BASE_ADDR  = 'h8000_0000,
   parameter int                  SIZE_WORDS = 256,
   parameter int                  RD_LAT     = 4
) (
   input  logic                      i_clk,
   input  logic                      i_msrh_reset_n,

   input  logic                      i_mem_req_valid,
   input  msrh_l2_pkg::l2_mem_req_t  i_mem_req,
   output logic                      o_mem_req_ready,

   output logic                      o_mem_resp_valid,
   output msrh_l2_pkg::l2_mem_resp_t o_mem_resp,
   input  logic                      i_mem_resp_ready
);

   localparam int BYTE_W = msrh_l2_pkg::DATA_W / 8;
   localparam int OFS_W  = $clog2(BYTE_W);
   localparam int IDX_W  = (SIZE_WORDS > 1) ? $clog2(SIZE_WORDS) : 1;

   // size of the memory window in bytes
   localparam msrh_l2_pkg::paddr_t WINDOW_BYTES = msrh_l2_pkg::paddr_t'(SIZE_WORDS * BYTE_W);

   msrh_l2_pkg::l2_data_t      r_mem [SIZE_WORDS];

   // read pipeline, head entry at RD_LAT-1
   logic [RD_LAT-1:0]          r_valid;
   msrh_l2_pkg::l2_mem_resp_t  r_resp [RD_LAT];

   logic                       r_active;
   logic                       w_stall;
   logic                       w_acc;
   logic                       w_rd_acc;
   logic                       w_wr_acc;
   msrh_l2_pkg::paddr_t        w_offset;
   logic [IDX_W-1:0]           w_index;
   msrh_l2_pkg::l2_mem_resp_t  w_rd_resp;

   // accept nothing until the first edge out of reset
   always_ff @(posedge i_clk) begin
      if (!i_msrh_reset_n) begin
         r_active <= 1'b0;
      end else begin
         r_active <= 1'b1;
      end
   end

   // head response waiting on its requester freezes everything
   assign w_stall         = r_valid[RD_LAT-1] & ~i_mem_resp_ready;
   assign o_mem_req_ready = r_active & ~w_stall;

   assign w_acc    = i_mem_req_valid & o_mem_req_ready;
   assign w_rd_acc = w_acc & (i_mem_req.req.cmd == msrh_l2_pkg::M_RD);
   assign w_wr_acc = w_acc & (i_mem_req.req.cmd == msrh_l2_pkg::M_WR);

   // word index inside the window
   assign w_offset = i_mem_req.req.addr - BASE_ADDR;
   assign w_index  = w_offset[OFS_W +: IDX_W];

   // read data is taken at the accepting edge, after any earlier write
   assign w_rd_resp = '{
      src:  i_mem_req.src,
      tag:  i_mem_req.req.tag,
      data: r_mem[w_index]
   };

   // byte-merged write
   always_ff @(posedge i_clk) begin
      if (w_wr_acc) begin
         for (int b = 0; b < BYTE_W; b++) begin
            if (i_mem_req.req.byte_en[b]) begin
               r_mem[w_index][b*8 +: 8] <= i_mem_req.req.data[b*8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_msrh_reset_n) begin
         r_valid <= '0;
      end else if (!w_stall) begin
         for (int i = RD_LAT - 1; i > 0; i--) begin
            r_valid[i] <= r_valid[i-1];
         end
         r_valid[0] <= w_rd_acc;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!w_stall) begin
         for (int i = RD_LAT - 1; i > 0; i--) begin
            r_resp[i] <= r_resp[i-1];
         end
         r_resp[0] <= w_rd_resp;
      end
   end

   assign o_mem_resp_valid = r_valid[RD_LAT-1];
   assign o_mem_resp       = r_resp[RD_LAT-1];

   a_addr_in_window : assert property (
      @(posedge i_clk) disable iff (!i_msrh_reset_n)
      w_acc |-> (w_offset < WINDOW_BYTES)
   );

   // a stalled response is still there, unchanged, on the next edge
   a_resp_stable : assert property (
      @(posedge i_clk) disable iff (!i_msrh_reset_n)
      w_stall |=> (o_mem_resp_valid && $stable(o_mem_resp))
   );

endmodule

// ==== hw/msrh_l2_resp_router.sv ====
module msrh_l2_resp_router (
   input  logic                      i_mem_resp_valid,
   input  msrh_l2_pkg::l2_mem_resp_t i_mem_resp,
   output logic                      o_mem_resp_ready,

   output logic                      o_elf_resp_valid,
   output msrh_l2_pkg::l2_resp_t     o_elf_resp,
   input  logic                      i_elf_resp_ready,

   output logic                      o_ic_resp_valid,
   output msrh_l2_pkg::l2_resp_t     o_ic_resp,
   input  logic                      i_ic_resp_ready,

   output logic                      o_l1d_resp_valid,
   output msrh_l2_pkg::l2_resp_t     o_l1d_resp,
   input  logic                      i_l1d_resp_ready,

   output logic                      o_ptw_resp_valid,
   output msrh_l2_pkg::l2_resp_t     o_ptw_resp,
   input  logic                      i_ptw_resp_ready
);

   localparam int N_SRC = 1 << msrh_l2_pkg::SRC_W;

   logic [N_SRC-1:0]       w_resp_valid;
   logic [N_SRC-1:0]       w_port_ready;
   msrh_l2_pkg::l2_resp_t  w_resp;

   // source id decoded to a single port
   assign w_resp_valid = i_mem_resp_valid ? (N_SRC'(1) << i_mem_resp.src) : '0;

   // the source id is dropped, the requester's own tag goes back
   assign w_resp = '{tag: i_mem_resp.tag, data: i_mem_resp.data};

   assign o_elf_resp_valid = w_resp_valid[msrh_l2_pkg::SRC_ELF];
   assign o_ic_resp_valid  = w_resp_valid[msrh_l2_pkg::SRC_IC];
   assign o_l1d_resp_valid = w_resp_valid[msrh_l2_pkg::SRC_L1D];
   assign o_ptw_resp_valid = w_resp_valid[msrh_l2_pkg::SRC_PTW];

   assign o_elf_resp = w_resp;
   assign o_ic_resp  = w_resp;
   assign o_l1d_resp = w_resp;
   assign o_ptw_resp = w_resp;

   assign w_port_ready[msrh_l2_pkg::SRC_ELF] = i_elf_resp_ready;
   assign w_port_ready[msrh_l2_pkg::SRC_IC]  = i_ic_resp_ready;
   assign w_port_ready[msrh_l2_pkg::SRC_L1D] = i_l1d_resp_ready;
   assign w_port_ready[msrh_l2_pkg::SRC_PTW] = i_ptw_resp_ready;

   // only the addressed requester can release the RAM
   assign o_mem_resp_ready = w_port_ready[i_mem_resp.src];

   always_comb begin
      a_one_resp_valid : assert ($onehot0({o_elf_resp_valid, o_ic_resp_valid,
                                           o_l1d_resp_valid, o_ptw_resp_valid}));
   end

endmodule

// ==== hw/msrh_l2_subsys.sv ====
module msrh_l2_subsys #(
   parameter msrh_l2_pkg::paddr_t BASE_ADDR  = 'h8000_0000,
   parameter int                  SIZE_WORDS = 256,
   parameter int                  RD_LAT     = 4
) (
   input  logic                   i_clk,
   input  logic                   i_msrh_reset_n,

   // ELF loader
   input  logic                   i_elf_req_valid,
   input  msrh_l2_pkg::l2_req_t   i_elf_req,
   output logic                   o_elf_req_ready,
   output logic                   o_elf_resp_valid,
   output msrh_l2_pkg::l2_resp_t  o_elf_resp,
   input  logic                   i_elf_resp_ready,

   // instruction cache
   input  logic                   i_ic_req_valid,
   input  msrh_l2_pkg::l2_req_t   i_ic_req,
   output logic                   o_ic_req_ready,
   output logic                   o_ic_resp_valid,
   output msrh_l2_pkg::l2_resp_t  o_ic_resp,
   input  logic                   i_ic_resp_ready,

   // L1 data cache
   input  logic                   i_l1d_req_valid,
   input  msrh_l2_pkg::l2_req_t   i_l1d_req,
   output logic                   o_l1d_req_ready,
   output logic                   o_l1d_resp_valid,
   output msrh_l2_pkg::l2_resp_t  o_l1d_resp,
   input  logic                   i_l1d_resp_ready,

   // page table walker
   input  logic                   i_ptw_req_valid,
   input  msrh_l2_pkg::l2_req_t   i_ptw_req,
   output logic                   o_ptw_req_ready,
   output logic                   o_ptw_resp_valid,
   output msrh_l2_pkg::l2_resp_t  o_ptw_resp,
   input  logic                   i_ptw_resp_ready
);

   logic                       w_mem_req_valid;
   msrh_l2_pkg::l2_mem_req_t   w_mem_req;
   logic                       w_mem_req_ready;

   logic                       w_mem_resp_valid;
   msrh_l2_pkg::l2_mem_resp_t  w_mem_resp;
   logic                       w_mem_resp_ready;

   msrh_l2_req_arbiter u_msrh_l2_req_arbiter (
      .i_clk           (i_clk          ),
      .i_elf_req_valid (i_elf_req_valid),
      .i_elf_req       (i_elf_req      ),
      .o_elf_req_ready (o_elf_req_ready),
      .i_ic_req_valid  (i_ic_req_valid ),
      .i_ic_req        (i_ic_req       ),
      .o_ic_req_ready  (o_ic_req_ready ),
      .i_l1d_req_valid (i_l1d_req_valid),
      .i_l1d_req       (i_l1d_req      ),
      .o_l1d_req_ready (o_l1d_req_ready),
      .i_ptw_req_valid (i_ptw_req_valid),
      .i_ptw_req       (i_ptw_req      ),
      .o_ptw_req_ready (o_ptw_req_ready),
      .o_mem_req_valid (w_mem_req_valid),
      .o_mem_req       (w_mem_req      ),
      .i_mem_req_ready (w_mem_req_ready)
   );

   msrh_l2_ram #(
      .BASE_ADDR  (BASE_ADDR ),
      .SIZE_WORDS (SIZE_WORDS),
      .RD_LAT     (RD_LAT    )
   ) u_msrh_l2_ram (
      .i_clk            (i_clk           ),
      .i_msrh_reset_n   (i_msrh_reset_n  ),
      .i_mem_req_valid  (w_mem_req_valid ),
      .i_mem_req        (w_mem_req       ),
      .o_mem_req_ready  (w_mem_req_ready ),
      .o_mem_resp_valid (w_mem_resp_valid),
      .o_mem_resp       (w_mem_resp      ),
      .i_mem_resp_ready (w_mem_resp_ready)
   );

   msrh_l2_resp_router u_msrh_l2_resp_router (
      .i_mem_resp_valid (w_mem_resp_valid),
      .i_mem_resp       (w_mem_resp      ),
      .o_mem_resp_ready (w_mem_resp_ready),
      .o_elf_resp_valid (o_elf_resp_valid),
      .o_elf_resp       (o_elf_resp      ),
      .i_elf_resp_ready (i_elf_resp_ready),
      .o_ic_resp_valid  (o_ic_resp_valid ),
      .o_ic_resp        (o_ic_resp       ),
      .i_ic_resp_ready  (i_ic_resp_ready ),
      .o_l1d_resp_valid (o_l1d_resp_valid),
      .o_l1d_resp       (o_l1d_resp      ),
      .i_l1d_resp_ready (i_l1d_resp_ready),
      .o_ptw_resp_valid (o_ptw_resp_valid),
      .o_ptw_resp       (o_ptw_resp      ),
      .i_ptw_resp_ready (i_ptw_resp_ready)
   );

endmodule

// ==== test/msrh_l2_tb_table.svh ====
`ifndef MSRH_L2_TB_TABLE_SVH
`define MSRH_L2_TB_TABLE_SVH

// ports: 0 elf, 1 ic, 2 l1d, 3 ptw
// ctl: step, valid mask, resp_ready mask while holding, stall cycles, random write data
// req: step, port, cmd, addr, tag, data, byte_en
localparam int N_STEPS  = 12;
localparam int MAX_HOLD = 3;

task automatic load_table();
   set_ctl(0, 4'b0100, 4'hf, 0, 1'b0);
   set_req(0, 2, msrh_l2_pkg::M_WR, 32'h8000_0000, 4'h1, 64'h1122_3344_5566_7788, 8'hff);
   set_ctl(1, 4'b0100, 4'hf, 0, 1'b0);
   set_req(1, 2, msrh_l2_pkg::M_RD, 32'h8000_0000, 4'h2, 64'h0, 8'h00);
   // full word first, then two partial merges on top of it
   set_ctl(2, 4'b0001, 4'hf, 0, 1'b1);
   set_req(2, 0, msrh_l2_pkg::M_WR, 32'h8000_0008, 4'h3, 64'h0, 8'hff);
   set_ctl(3, 4'b0001, 4'hf, 0, 1'b0);
   set_req(3, 0, msrh_l2_pkg::M_WR, 32'h8000_0008, 4'h4, 64'ha5a5_a5a5_a5a5_a5a5, 8'h0f);
   set_ctl(4, 4'b0001, 4'hf, 0, 1'b0);
   set_req(4, 0, msrh_l2_pkg::M_WR, 32'h8000_0008, 4'h5, 64'h0123_4567_89ab_cdef, 8'ha0);
   set_ctl(5, 4'b0010, 4'hf, 0, 1'b0);
   set_req(5, 1, msrh_l2_pkg::M_RD, 32'h8000_0008, 4'h6, 64'h0, 8'h00);
   // all four ports at once
   set_ctl(6, 4'b1111, 4'hf, 0, 1'b1);
   set_req(6, 0, msrh_l2_pkg::M_WR, 32'h8000_0010, 4'h7, 64'h0, 8'hff);
   set_req(6, 1, msrh_l2_pkg::M_WR, 32'h8000_0018, 4'h8, 64'h0, 8'hff);
   set_req(6, 2, msrh_l2_pkg::M_WR, 32'h8000_0020, 4'h9, 64'h0, 8'hff);
   set_req(6, 3, msrh_l2_pkg::M_WR, 32'h8000_0028, 4'ha, 64'h0, 8'hff);
   set_ctl(7, 4'b1111, 4'hf, 0, 1'b0);
   set_req(7, 0, msrh_l2_pkg::M_RD, 32'h8000_0028, 4'hb, 64'h0, 8'h00);
   set_req(7, 1, msrh_l2_pkg::M_RD, 32'h8000_0020, 4'hc, 64'h0, 8'h00);
   set_req(7, 2, msrh_l2_pkg::M_RD, 32'h8000_0018, 4'hd, 64'h0, 8'h00);
   set_req(7, 3, msrh_l2_pkg::M_RD, 32'h8000_0010, 4'he, 64'h0, 8'h00);
   // l1d response held while ptw sits in the pipeline and ic waits at the arbiter
   set_ctl(8, 4'b1110, 4'b1011, 3, 1'b0);
   set_req(8, 1, msrh_l2_pkg::M_RD, 32'h8000_0000, 4'h1, 64'h0, 8'h00);
   set_req(8, 2, msrh_l2_pkg::M_RD, 32'h8000_0008, 4'h2, 64'h0, 8'h00);
   set_req(8, 3, msrh_l2_pkg::M_RD, 32'h8000_0010, 4'h3, 64'h0, 8'h00);
   set_ctl(9, 4'b1001, 4'b0111, 2, 1'b0);
   set_req(9, 0, msrh_l2_pkg::M_RD, 32'h8000_0018, 4'h4, 64'h0, 8'h00);
   set_req(9, 3, msrh_l2_pkg::M_RD, 32'h8000_0020, 4'h5, 64'h0, 8'h00);
   set_ctl(10, 4'b1000, 4'hf, 0, 1'b1);
   set_req(10, 3, msrh_l2_pkg::M_WR, 32'h8000_0028, 4'h6, 64'h0, 8'h3c);
   // partial merge over random data, read back
   set_ctl(11, 4'b0100, 4'hf, 0, 1'b0);
   set_req(11, 2, msrh_l2_pkg::M_RD, 32'h8000_0028, 4'h7, 64'h0, 8'h00);
endtask

`endif

// ==== test/msrh_l2_tb.sv ====
module msrh_l2_tb;

   localparam msrh_l2_pkg::paddr_t BASE_ADDR = 32'h8000_0000;
   localparam int SIZE_WORDS = 256;
   // below the port count, so a stalled head can block a waiting request
   localparam int RD_LAT     = 2;
   localparam int N_PORTS    = 4;

   `include "msrh_l2_tb_table.svh"

   localparam int LIMIT = N_STEPS * (RD_LAT + MAX_HOLD + 2) + 20;

   typedef struct {
      logic [3:0]           valid;
      logic [3:0]           rdy;
      int                   hold;
      logic                 rnd;
      msrh_l2_pkg::l2_req_t req [N_PORTS];
   } step_t;

   typedef struct {
      int                    port;
      msrh_l2_pkg::l2_tag_t  tag;
      msrh_l2_pkg::l2_data_t data;
      int                    due;
   } exp_t;

   logic                  clk;
   logic                  reset_n;
   logic [3:0]            req_valid;
   logic [3:0]            req_ready;
   logic [3:0]            resp_valid;
   logic [3:0]            resp_ready;
   msrh_l2_pkg::l2_req_t  req_d [N_PORTS];
   msrh_l2_pkg::l2_resp_t resp [N_PORTS];

   step_t                 steps [N_STEPS];
   msrh_l2_pkg::l2_data_t ref_mem [SIZE_WORDS];
   exp_t                  exp_q [$];
   logic [31:0]           lfsr;
   int                    cyc;

   msrh_l2_subsys #(
      .BASE_ADDR  (BASE_ADDR ),
      .SIZE_WORDS (SIZE_WORDS),
      .RD_LAT     (RD_LAT    )
   ) msrh_l2_subsys_inst (
      .i_clk            (clk          ),
      .i_msrh_reset_n   (reset_n      ),
      .i_elf_req_valid  (req_valid[0] ),
      .i_elf_req        (req_d[0]     ),
      .o_elf_req_ready  (req_ready[0] ),
      .o_elf_resp_valid (resp_valid[0]),
      .o_elf_resp       (resp[0]      ),
      .i_elf_resp_ready (resp_ready[0]),
      .i_ic_req_valid   (req_valid[1] ),
      .i_ic_req         (req_d[1]     ),
      .o_ic_req_ready   (req_ready[1] ),
      .o_ic_resp_valid  (resp_valid[1]),
      .o_ic_resp        (resp[1]      ),
      .i_ic_resp_ready  (resp_ready[1]),
      .i_l1d_req_valid  (req_valid[2] ),
      .i_l1d_req        (req_d[2]     ),
      .o_l1d_req_ready  (req_ready[2] ),
      .o_l1d_resp_valid (resp_valid[2]),
      .o_l1d_resp       (resp[2]      ),
      .i_l1d_resp_ready (resp_ready[2]),
      .i_ptw_req_valid  (req_valid[3] ),
      .i_ptw_req        (req_d[3]     ),
      .o_ptw_req_ready  (req_ready[3] ),
      .o_ptw_resp_valid (resp_valid[3]),
      .o_ptw_resp       (resp[3]      ),
      .i_ptw_resp_ready (resp_ready[3])
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT) begin
         $display("timeout: the tests did not finish within %0d cycles", LIMIT);
         fail();
      end
   end

   task automatic fail();
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic set_ctl(int s, logic [3:0] valid, logic [3:0] rdy, int hold, logic rnd);
      steps[s].valid = valid;
      steps[s].rdy   = rdy;
      steps[s].hold  = hold;
      steps[s].rnd   = rnd;
   endtask

   task automatic set_req(int s, int p, msrh_l2_pkg::mem_cmd_t cmd, logic [31:0] addr,
                          logic [3:0] tag, logic [63:0] data, logic [7:0] be);
      steps[s].req[p] = '{cmd: cmd, addr: addr, tag: tag, data: data, byte_en: be};
   endtask

   function automatic string pname(int p);
      case (p)
         0: return "elf";
         1: return "ic";
         2: return "l1d";
         default: return "ptw";
      endcase
   endfunction

   // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic msrh_l2_pkg::l2_data_t rand_word();
      logic                  fb;
      msrh_l2_pkg::l2_data_t w;
      for (int i = 0; i < 64; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         w[i] = fb;
      end
      return w;
   endfunction

   // l1d, then ptw, then ic, then elf
   function automatic int winner(logic [3:0] v);
      if (v[2]) return 2;
      if (v[3]) return 3;
      if (v[1]) return 1;
      if (v[0]) return 0;
      return -1;
   endfunction

   task automatic check_val(string name, logic [63:0] exp, logic [63:0] got);
      assert (got === exp) else begin
         $display("Error %s expected %h got %h", name, exp, got);
         fail();
      end
   endtask

   // called once per cycle at the falling edge, where every signal is settled
   task automatic observe();
      int   win;
      int   idx;
      logic stall;
      logic exp_rdy;
      exp_t e;
      win   = winner(req_valid);
      stall = (exp_q.size() != 0) && (exp_q[0].due == cyc) && !resp_ready[exp_q[0].port];
      for (int p = 0; p < N_PORTS; p++) begin
         exp_rdy = req_valid[p] && (p == win) && !stall;
         check_val($sformatf("o_%s_req_ready", pname(p)), 64'(exp_rdy), 64'(req_ready[p]));
      end
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
         e = exp_q[0];
         for (int p = 0; p < N_PORTS; p++) begin
            check_val($sformatf("o_%s_resp_valid", pname(p)), 64'(p == e.port),
                      64'(resp_valid[p]));
         end
         check_val($sformatf("o_%s_resp.tag", pname(e.port)), 64'(e.tag),
                   64'(resp[e.port].tag));
         check_val($sformatf("o_%s_resp.data", pname(e.port)), e.data, resp[e.port].data);
         if (resp_ready[e.port]) begin
            void'(exp_q.pop_front());
         end else begin
            // every read in flight waits one more cycle
            foreach (exp_q[i]) exp_q[i].due++;
         end
      end else begin
         check_val("resp_valid", 64'h0, 64'(resp_valid));
      end
      for (int p = 0; p < N_PORTS; p++) begin
         if (req_valid[p] && req_ready[p]) begin
            idx = int'((req_d[p].addr - BASE_ADDR) >> 3);
            if (req_d[p].cmd == msrh_l2_pkg::M_WR) begin
               for (int b = 0; b < 8; b++) begin
                  if (req_d[p].byte_en[b]) ref_mem[idx][b*8 +: 8] = req_d[p].data[b*8 +: 8];
               end
            end else begin
               exp_q.push_back('{port: p, tag: req_d[p].tag, data: ref_mem[idx],
                                 due: cyc + RD_LAT});
            end
         end
      end
   endtask

   task automatic apply_step(int s);
      logic [3:0]           pend;
      logic [3:0]           done;
      int                   stalls;
      msrh_l2_pkg::l2_req_t r;
      for (int p = 0; p < N_PORTS; p++) begin
         if (steps[s].valid[p]) begin
            r = steps[s].req[p];
            if (steps[s].rnd && r.cmd == msrh_l2_pkg::M_WR) r.data = rand_word();
            req_d[p]     = r;
            req_valid[p] = 1'b1;
         end
      end
      resp_ready = (steps[s].hold > 0) ? steps[s].rdy : 4'hf;
      stalls     = 0;
      pend       = steps[s].valid;
      while (pend != 0 || exp_q.size() != 0) begin
         @(negedge clk);
         done = req_valid & req_ready;
         if (|(resp_valid & ~resp_ready)) stalls++;
         observe();
         @(posedge clk);
         #1;
         pend      = pend & ~done;
         req_valid = req_valid & ~done;
         if (stalls >= steps[s].hold) resp_ready = 4'hf;
      end
   endtask

   initial begin
      clk        = 1'b0;
      reset_n    = 1'b0;
      req_valid  = 4'hf;
      resp_ready = 4'hf;
      cyc        = 0;
      lfsr       = 32'hb6a7_c541;
      for (int p = 0; p < N_PORTS; p++) req_d[p] = '0;
      load_table();
      repeat (4) @(posedge clk);
      // requests raised during reset are not accepted
      @(negedge clk);
      check_val("req_ready in reset", 64'h0, 64'(req_ready));
      @(posedge clk);
      #1;
      req_valid = '0;
      reset_n   = 1'b1;
      @(negedge clk);
      check_val("resp_valid after reset", 64'h0, 64'(resp_valid));
      repeat (2) @(posedge clk);
      #1;
      for (int s = 0; s < N_STEPS; s++) begin
         apply_step(s);
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+test
hw/msrh_l2_pkg.sv
hw/msrh_l2_req_arbiter.sv
hw/msrh_l2_ram.sv
hw/msrh_l2_resp_router.sv
hw/msrh_l2_subsys.sv
test/msrh_l2_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the L2 request path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module msrh_l2_tb -o msrh_l2_sim
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

output=$(./obj_dir/msrh_l2_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
   exit 0
fi
echo "pass message not found"
exit 1
